//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP       ?= tb_age_issue_unit
RTL_TOP   ?= age_issue_unit
FLIST     ?= age_issue_unit.f
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FLIST) --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf obj_dir $(LOG)

//--- age_issue_unit.f
design/issue_pkg.sv
design/sync_rst.sv
design/tag_alloc.sv
design/oldest_select.sv
design/issue_queue.sv
design/issue_arbiter.sv
design/age_issue_unit.sv
tb/tb_clock.sv
tb/tb_age_issue_unit.sv

//--- design/age_issue_unit.sv
`timescale 1ns/1ps

module age_issue_unit
	import issue_pkg::*;
(
	input  logic clk,
	input  logic rst_i,
	input  logic dispatch_valid_i,
	input  dispatch_t dispatch_i,
	input  logic wakeup_valid_i,
	input  tag_t wakeup_tag_i,
	input  logic retire_i,
	output logic dispatch_stall_o,
	output logic issue_valid_o,
	output issue_t issue_o
);

	logic rst;
	logic alloc;
	tag_t alloc_tag;
	logic int_full;
	logic mem_full;
	logic int_valid;
	logic mem_valid;
	issue_t int_cand;
	issue_t mem_cand;
	logic int_grant;
	logic mem_grant;

	sync_rst u_sync_rst (
		.clk   (clk),
		.rst_i (rst_i),
		.rst_o (rst)
	);

	tag_alloc u_tag_alloc (
		.clk              (clk),
		.rst_i            (rst),
		.dispatch_valid_i (dispatch_valid_i),
		.queue_sel_i      (dispatch_i.queue_sel),
		.int_full_i       (int_full),
		.mem_full_i       (mem_full),
		.retire_i         (retire_i),
		.alloc_o          (alloc),
		.alloc_tag_o      (alloc_tag),
		.dispatch_stall_o (dispatch_stall_o)
	);

	issue_queue #(.QUEUE_ID(QUEUE_INT)) int_queue (
		.clk            (clk),
		.rst_i          (rst),
		.alloc_i        (alloc),
		.alloc_tag_i    (alloc_tag),
		.dispatch_i     (dispatch_i),
		.wakeup_valid_i (wakeup_valid_i),
		.wakeup_tag_i   (wakeup_tag_i),
		.grant_i        (int_grant),
		.full_o         (int_full),
		.cand_valid_o   (int_valid),
		.cand_o         (int_cand)
	);

	issue_queue #(.QUEUE_ID(QUEUE_MEM)) mem_queue (
		.clk            (clk),
		.rst_i          (rst),
		.alloc_i        (alloc),
		.alloc_tag_i    (alloc_tag),
		.dispatch_i     (dispatch_i),
		.wakeup_valid_i (wakeup_valid_i),
		.wakeup_tag_i   (wakeup_tag_i),
		.grant_i        (mem_grant),
		.full_o         (mem_full),
		.cand_valid_o   (mem_valid),
		.cand_o         (mem_cand)
	);

	issue_arbiter u_issue_arbiter (
		.clk           (clk),
		.rst_i         (rst),
		.int_valid_i   (int_valid),
		.int_cand_i    (int_cand),
		.mem_valid_i   (mem_valid),
		.mem_cand_i    (mem_cand),
		.int_grant_o   (int_grant),
		.mem_grant_o   (mem_grant),
		.issue_valid_o (issue_valid_o),
		.issue_o       (issue_o)
	);

endmodule

//--- design/issue_arbiter.sv
`timescale 1ns/1ps

module issue_arbiter
	import issue_pkg::*;
(
	input  logic clk,
	input  logic rst_i,
	input  logic int_valid_i,
	input  issue_t int_cand_i,
	input  logic mem_valid_i,
	input  issue_t mem_cand_i,
	output logic int_grant_o,
	output logic mem_grant_o,
	output logic issue_valid_o,
	output issue_t issue_o
);

	logic win_en;
	logic win_idx;
	issue_t win_cand;

	// int sits in slot 0 and mem in slot 1
	oldest_select #(.COUNT(2)) u_age (
		.en_i  ({mem_valid_i, int_valid_i}),
		.tag_i ({mem_cand_i.tag, int_cand_i.tag}),
		.en_o  (win_en),
		.tag_o (),
		.idx_o (win_idx)
	);

	assign int_grant_o = win_en && !win_idx;
	assign mem_grant_o = win_en && win_idx;
	assign win_cand = win_idx ? mem_cand_i : int_cand_i;

	always_ff @(posedge clk or posedge rst_i) begin
		if (rst_i) begin
			issue_valid_o <= 1'b0;
		end else begin
			issue_valid_o <= win_en;
		end
	end

	always_ff @(posedge clk) begin
		if (win_en) begin
			issue_o <= win_cand;
		end
	end

endmodule

//--- design/issue_pkg.sv
package issue_pkg;

	localparam int TAG_IDX_W = 3;
	localparam int TAG_COUNT = 8;
	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_IDX_W = $clog2(QUEUE_DEPTH);
	localparam int IMM_W = 16;

	localparam logic QUEUE_INT = 1'b0;
	localparam logic QUEUE_MEM = 1'b1;

	// reorder tag with the wrap bit on top
	typedef struct packed {
		logic wrap;
		logic [TAG_IDX_W-1:0] idx;
	} tag_t;

	typedef struct packed {
		logic queue_sel;
		logic ready;
		logic [IMM_W-1:0] imm;
	} dispatch_t;

	typedef struct packed {
		tag_t tag;
		logic queue_sel;
		logic [IMM_W-1:0] imm;
	} issue_t;

	// true when a is older than b across the wrap
	function automatic logic tag_older(tag_t a, tag_t b);
		if (a.wrap == b.wrap) begin
			return a.idx < b.idx;
		end
		// on different laps the one still on the old lap has the larger index
		return a.idx > b.idx;
	endfunction

	// step a loop pointer and toggle wrap at the end of the ring
	function automatic tag_t tag_next(tag_t t);
		tag_t n;
		n = t;
		if (t.idx == TAG_IDX_W'(TAG_COUNT - 1)) begin
			n.idx = '0;
			n.wrap = ~t.wrap;
		end else begin
			n.idx = t.idx + 1'b1;
		end
		return n;
	endfunction

endpackage

//--- design/issue_queue.sv
`timescale 1ns/1ps

module issue_queue
	import issue_pkg::*;
#(
	parameter logic QUEUE_ID = QUEUE_INT
) (
	input  logic clk,
	input  logic rst_i,
	input  logic alloc_i,
	input  tag_t alloc_tag_i,
	input  dispatch_t dispatch_i,
	input  logic wakeup_valid_i,
	input  tag_t wakeup_tag_i,
	input  logic grant_i,
	output logic full_o,
	output logic cand_valid_o,
	output issue_t cand_o
);

	logic [QUEUE_DEPTH-1:0] valid_q;
	logic [QUEUE_DEPTH-1:0] ready_q;
	tag_t [QUEUE_DEPTH-1:0] tag_q;
	logic [QUEUE_DEPTH-1:0][IMM_W-1:0] imm_q;

	logic write_en;
	logic [QUEUE_IDX_W-1:0] free_idx;
	logic [QUEUE_IDX_W-1:0] sel_idx;
	logic wake_at_write;
	tag_t sel_tag;

	assign full_o = &valid_q;
	assign write_en = alloc_i && (dispatch_i.queue_sel == QUEUE_ID);
	// wakeup can land in the same cycle as its own dispatch
	assign wake_at_write = wakeup_valid_i && (wakeup_tag_i == alloc_tag_i);

	// lowest free slot
	always_comb begin
		free_idx = '0;
		for (int i = QUEUE_DEPTH - 1; i >= 0; i--) begin
			if (!valid_q[i]) begin
				free_idx = QUEUE_IDX_W'(i);
			end
		end
	end

	oldest_select #(.COUNT(QUEUE_DEPTH)) u_select (
		.en_i  (valid_q & ready_q),
		.tag_i (tag_q),
		.en_o  (cand_valid_o),
		.tag_o (sel_tag),
		.idx_o (sel_idx)
	);

	assign cand_o = '{tag: sel_tag, queue_sel: QUEUE_ID, imm: imm_q[sel_idx]};

	always_ff @(posedge clk or posedge rst_i) begin
		if (rst_i) begin
			valid_q <= '0;
			ready_q <= '0;
		end else begin
			for (int i = 0; i < QUEUE_DEPTH; i++) begin
				if (wakeup_valid_i && valid_q[i] && tag_q[i] == wakeup_tag_i) begin
					ready_q[i] <= 1'b1;
				end
			end
			if (grant_i) begin
				valid_q[sel_idx] <= 1'b0;
			end
			// write_en never reaches a full queue so the chosen slot is free
			if (write_en) begin
				valid_q[free_idx] <= 1'b1;
				ready_q[free_idx] <= dispatch_i.ready || wake_at_write;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (write_en) begin
			tag_q[free_idx] <= alloc_tag_i;
			imm_q[free_idx] <= dispatch_i.imm;
		end
	end

endmodule

//--- design/oldest_select.sv
`timescale 1ns/1ps

module oldest_select
	import issue_pkg::*;
#(
	parameter int COUNT = 4,
	parameter int IDX_W = (COUNT > 1) ? $clog2(COUNT) : 1
) (
	input  logic [COUNT-1:0] en_i,
	input  tag_t [COUNT-1:0] tag_i,
	output logic en_o,
	output tag_t tag_o,
	output logic [IDX_W-1:0] idx_o
);

	if (COUNT == 1) begin : g_leaf
		assign en_o = en_i[0];
		assign tag_o = tag_i[0];
		assign idx_o = '0;
	end else begin : g_node
		localparam int LO = COUNT / 2;
		localparam int HI = COUNT - LO;
		localparam int LO_W = (LO > 1) ? $clog2(LO) : 1;
		localparam int HI_W = (HI > 1) ? $clog2(HI) : 1;

		logic en_lo;
		logic en_hi;
		tag_t tag_lo;
		tag_t tag_hi;
		logic [LO_W-1:0] idx_lo;
		logic [HI_W-1:0] idx_hi;
		logic pick_hi;

		oldest_select #(.COUNT(LO)) u_lo (
			.en_i  (en_i[LO-1:0]),
			.tag_i (tag_i[LO-1:0]),
			.en_o  (en_lo),
			.tag_o (tag_lo),
			.idx_o (idx_lo)
		);

		oldest_select #(.COUNT(HI)) u_hi (
			.en_i  (en_i[COUNT-1:LO]),
			.tag_i (tag_i[COUNT-1:LO]),
			.en_o  (en_hi),
			.tag_o (tag_hi),
			.idx_o (idx_hi)
		);

		// a disabled side always loses and ties go to the low half
		assign pick_hi = en_hi && (!en_lo || tag_older(tag_hi, tag_lo));

		assign en_o = en_lo || en_hi;
		assign tag_o = pick_hi ? tag_hi : tag_lo;
		assign idx_o = pick_hi ? IDX_W'(LO) + IDX_W'(idx_hi) : IDX_W'(idx_lo);
	end

endmodule

//--- design/sync_rst.sv
`timescale 1ns/1ps

module sync_rst (
	input  logic clk,
	input  logic rst_i,
	output logic rst_o
);

	logic rst_meta;
	logic rst_sync;

	always_ff @(posedge clk or posedge rst_i) begin
		if (rst_i) begin
			rst_meta <= 1'b1;
			rst_sync <= 1'b1;
		end else begin
			rst_meta <= 1'b0;
			rst_sync <= rst_meta;
		end
	end

	assign rst_o = rst_sync;

endmodule

//--- design/tag_alloc.sv
`timescale 1ns/1ps

module tag_alloc
	import issue_pkg::*;
(
	input  logic clk,
	input  logic rst_i,
	input  logic dispatch_valid_i,
	input  logic queue_sel_i,
	input  logic int_full_i,
	input  logic mem_full_i,
	input  logic retire_i,
	output logic alloc_o,
	output tag_t alloc_tag_o,
	output logic dispatch_stall_o
);

	tag_t head;
	tag_t tail;
	logic ring_full;
	logic ring_empty;
	logic queue_full;

	// same index on a different lap
	assign ring_full = (head.idx == tail.idx) && (head.wrap != tail.wrap);
	assign ring_empty = (head == tail);

	assign queue_full = (queue_sel_i == QUEUE_MEM) ? mem_full_i : int_full_i;
	assign dispatch_stall_o = ring_full || queue_full;
	assign alloc_o = dispatch_valid_i && !dispatch_stall_o;
	assign alloc_tag_o = tail;

	always_ff @(posedge clk or posedge rst_i) begin
		if (rst_i) begin
			head <= '0;
			tail <= '0;
		end else begin
			if (alloc_o) begin
				tail <= tag_next(tail);
			end
			// nothing to free on an empty ring
			if (retire_i && !ring_empty) begin
				head <= tag_next(head);
			end
		end
	end

endmodule

//--- tb/issue_tests.dat
# name command a b c d e (hex)
# dispatch/offer: a=queue b=ready c=imm d=wakeup e=wakeup tag; wakeup: a=tag {wrap,idx}
reset expect_quiet 0 0 0 0 0
reset expect_stall 0 0 0 0 0
ready_order dispatch 0 1 00a0 0 0
ready_order dispatch 1 1 00a1 0 0
ready_order dispatch 0 1 00a2 0 0
ready_order dispatch 1 1 00a3 0 0
ready_order drain 0 0 0 0 0
ready_order retire 0 0 0 0 0
ready_order retire 0 0 0 0 0
ready_order retire 0 0 0 0 0
ready_order retire 0 0 0 0 0
wakeup_reorder dispatch 0 0 00b4 0 0
wakeup_reorder dispatch 0 1 00b5 0 0
wakeup_reorder dispatch 1 1 00b6 1 4
wrap dispatch 0 0 00c7 0 0
wrap dispatch 1 1 00c8 1 7
wrap drain 0 0 0 0 0
wrap retire 0 0 0 0 0
wrap retire 0 0 0 0 0
wrap retire 0 0 0 0 0
wrap retire 0 0 0 0 0
wrap retire 0 0 0 0 0
queue_full dispatch 0 0 00d1 0 0
queue_full dispatch 0 0 00d2 0 0
queue_full dispatch 0 0 00d3 0 0
queue_full dispatch 0 0 00d4 0 0
queue_full offer 0 1 00d5 0 0
queue_full expect_stall 1 0 0 0 0
queue_full wakeup 9 0 0 0 0
queue_full accept 0 0 0 0 0
tag_full dispatch 1 0 00e6 0 0
tag_full dispatch 1 0 00e7 0 0
tag_full dispatch 1 0 00e0 0 0
tag_full offer 1 1 00e1 0 0
tag_full expect_stall 1 0 0 0 0
tag_full retire 0 0 0 0 0
tag_full accept 0 0 0 0 0
final_wrap wakeup 0 0 0 0 0
final_wrap wakeup a 0 0 0 0
final_wrap wakeup b 0 0 0 0
final_wrap wakeup c 0 0 0 0
final_wrap wakeup e 0 0 0 0
final_wrap wakeup f 0 0 0 0
final_wrap drain 0 0 0 0 0

//--- tb/tb_age_issue_unit.sv
`timescale 1ns/1ps

module tb_age_issue_unit
	import issue_pkg::*;
;

	logic clk;
	logic rst;
	logic dispatch_valid_i;
	dispatch_t dispatch_i;
	logic wakeup_valid_i;
	tag_t wakeup_tag_i;
	logic retire_i;
	logic dispatch_stall_o;
	logic issue_valid_o;
	issue_t issue_o;

	int errors;
	int line_count;
	int seed;
	int fd;
	int code;
	int gap;
	logic offered;
	string line;
	string tname;
	string cmd;
	logic [31:0] fa;
	logic [31:0] fb;
	logic [31:0] fc;
	logic [31:0] fd_w;
	logic [31:0] fe;

	// reference model state
	logic m_valid [8];
	logic m_ready [8];
	tag_t m_tag [8];
	logic m_q [8];
	logic [IMM_W-1:0] m_imm [8];
	tag_t sw_tag;
	int inflight;
	issue_t exp_q [$];

	tb_clock u_clock (.clk_o(clk), .rst_o(rst));

	age_issue_unit dut (
		.clk              (clk),
		.rst_i            (rst),
		.dispatch_valid_i (dispatch_valid_i),
		.dispatch_i       (dispatch_i),
		.wakeup_valid_i   (wakeup_valid_i),
		.wakeup_tag_i     (wakeup_tag_i),
		.retire_i         (retire_i),
		.dispatch_stall_o (dispatch_stall_o),
		.issue_valid_o    (issue_valid_o),
		.issue_o          (issue_o)
	);

	// lower index is older on the same lap and higher index across laps
	function automatic logic is_older(tag_t a, tag_t b);
		if (a.wrap == b.wrap) begin
			return a.idx < b.idx;
		end
		return a.idx > b.idx;
	endfunction

	function automatic tag_t next_tag(tag_t t);
		tag_t n;
		n.idx = t.idx + 3'd1;
		n.wrap = (t.idx == 3'd7) ? ~t.wrap : t.wrap;
		return n;
	endfunction

	function automatic logic model_busy();
		logic busy;
		busy = issue_valid_o || (exp_q.size() != 0);
		for (int i = 0; i < 8; i++) begin
			busy = busy || m_valid[i];
		end
		return busy;
	endfunction

	// mirror of the issue stage that steps on every edge
	always @(posedge clk) begin
		int win;
		int n_int;
		int n_mem;
		logic m_stall;
		logic qfull;
		issue_t exp;
		n_int = 0;
		n_mem = 0;
		for (int i = 0; i < 8; i++) begin
			if (m_valid[i] && m_q[i]) n_mem++;
			if (m_valid[i] && !m_q[i]) n_int++;
		end
		qfull = dispatch_i.queue_sel ? (n_mem == QUEUE_DEPTH) : (n_int == QUEUE_DEPTH);
		m_stall = (inflight == TAG_COUNT) || qfull;
		if (dispatch_valid_i) begin
			assert (dispatch_stall_o == m_stall) else begin
				errors++;
				$display("error %s stall: expected %0b, actual %0b", tname, m_stall,
					dispatch_stall_o);
			end
		end
		if (issue_valid_o) begin
			assert (exp_q.size() > 0) else begin
				errors++;
				$display("%s: the DUT issued %h while nothing was due", tname, issue_o);
			end
			if (exp_q.size() > 0) begin
				exp = exp_q.pop_front();
				assert (issue_o == exp) else begin
					errors++;
					$display("error %s: expected %h, actual %h", tname, exp, issue_o);
				end
			end
		end
		win = -1;
		for (int i = 0; i < 8; i++) begin
			if (m_valid[i] && m_ready[i] && (win < 0 || is_older(m_tag[i], m_tag[win]))) begin
				win = i;
			end
		end
		if (win >= 0) begin
			exp_q.push_back(issue_t'({m_tag[win], m_q[win], m_imm[win]}));
			m_valid[win] = 1'b0;
		end
		for (int i = 0; i < 8; i++) begin
			if (wakeup_valid_i && m_valid[i] && m_tag[i] == wakeup_tag_i) m_ready[i] = 1'b1;
		end
		if (retire_i && inflight > 0) inflight--;
		if (dispatch_valid_i && !m_stall) begin
			win = 0;
			while (m_valid[win]) win++;
			m_valid[win] = 1'b1;
			m_ready[win] = dispatch_i.ready || (wakeup_valid_i && wakeup_tag_i == sw_tag);
			m_tag[win] = sw_tag;
			m_q[win] = dispatch_i.queue_sel;
			m_imm[win] = dispatch_i.imm;
			inflight++;
			sw_tag = next_tag(sw_tag);
		end
	end

	task automatic offer_start();
		@(posedge clk);
		offered = 1'b1;
		dispatch_valid_i <= 1'b1;
		dispatch_i <= '{queue_sel: fa[0], ready: fb[0], imm: fc[IMM_W-1:0]};
		wakeup_valid_i <= fd_w[0];
		wakeup_tag_i <= tag_t'(fe[3:0]);
	endtask

	task automatic wait_accept();
		do begin
			@(posedge clk);
			wakeup_valid_i <= 1'b0;
		end while (dispatch_stall_o);
		dispatch_valid_i <= 1'b0;
		offered = 1'b0;
	endtask

	task automatic wake_tag();
		@(posedge clk);
		wakeup_valid_i <= 1'b1;
		wakeup_tag_i <= tag_t'(fa[3:0]);
		@(posedge clk);
		wakeup_valid_i <= 1'b0;
	endtask

	task automatic retire_oldest();
		@(posedge clk);
		retire_i <= 1'b1;
		@(posedge clk);
		retire_i <= 1'b0;
	endtask

	task automatic run_command();
		case (cmd)
			"dispatch": begin
				offer_start();
				wait_accept();
			end
			"offer": begin
				offer_start();
				@(posedge clk);
				wakeup_valid_i <= 1'b0;
			end
			"accept": wait_accept();
			"wakeup": wake_tag();
			"retire": retire_oldest();
			"idle": repeat (fa) @(posedge clk);
			"drain": do @(negedge clk); while (model_busy());
			"expect_stall": begin
				@(negedge clk);
				assert (dispatch_stall_o == fa[0]) else begin
					errors++;
					$display("error %s: expected %0b, actual %0b", tname, fa[0],
						dispatch_stall_o);
				end
			end
			"expect_quiet": begin
				@(negedge clk);
				assert (!issue_valid_o && !dispatch_stall_o) else begin
					errors++;
					$display("error %s: expected 00, actual %0b%0b", tname, issue_valid_o,
						dispatch_stall_o);
				end
			end
			default: begin
				errors++;
				$display("%s: unknown command %s in the test file", tname, cmd);
			end
		endcase
	endtask

	initial begin
		errors = 0;
		line_count = 0;
		seed = 29815;
		inflight = 0;
		offered = 1'b0;
		sw_tag = '0;
		tname = "reset";
		dispatch_valid_i = 1'b0;
		dispatch_i = '0;
		wakeup_valid_i = 1'b0;
		wakeup_tag_i = '0;
		retire_i = 1'b0;
		for (int i = 0; i < 8; i++) begin
			m_valid[i] = 1'b0;
			m_ready[i] = 1'b0;
		end
		fd = $fopen("tb/issue_tests.dat", "r");
		if (fd == 0) begin
			$display("cannot open tb/issue_tests.dat");
			$display("TEST RESULT: FAIL");
			$finish;
		end else begin
			while ($fgets(line, fd) > 0) begin
				if (line.len() > 1 && line[0] != 8'h23) line_count++;
			end
			$fclose(fd);
			fd = $fopen("tb/issue_tests.dat", "r");
			@(negedge rst);
			repeat (4) @(posedge clk);
			while ($fgets(line, fd) > 0) begin
				if (line.len() > 1 && line[0] != 8'h23) begin
					code = $sscanf(line, "%s %s %h %h %h %h %h", tname, cmd, fa, fb, fc,
						fd_w, fe);
					assert (code == 7) else begin
						errors++;
						$display("%s: test line has %0d fields instead of 7", tname, code);
					end
					run_command();
					// no gap while a dispatch is still offered
					gap = {$random(seed)} % 3;
					if (!offered) repeat (gap) @(posedge clk);
				end
			end
			$fclose(fd);
			$display("errors: %0d", errors);
			if (errors == 0) begin
				$display("TEST RESULT: PASS");
			end else begin
				$display("TEST RESULT: FAIL");
			end
			$finish;
		end
	end

	// watchdog allows 20 cycles per test line plus reset
	initial begin
		wait (line_count > 0);
		#((line_count * 20 + 24) * 40);
		$display("watchdog expired before the tests finished");
		$display("errors: %0d", errors);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk_o,
	output logic rst_o
);

	// 40 ns period
	initial begin
		clk_o = 1'b0;
		forever #20 clk_o = ~clk_o;
	end

	initial begin
		rst_o = 1'b1;
		repeat (16) @(posedge clk_o);
		rst_o <= 1'b0;
	end

endmodule
